// ==== list.f ====
rtl/sched_pkg.sv
rtl/id_pool.sv
rtl/rr_arbiter.sv
rtl/resource_scheduler.sv
rtl/payload_store.sv
rtl/sched_top.sv
tb/sched_asserts.sv
tb/sched_checker.sv
tb/tb_sched.sv

// ==== rtl/id_pool.sv ====
// ------------------------------------------------
// entry id pool
// keeps the active bitmap, offers the lowest free id
// as one-hot and frees ids handed back on dequeue
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module id_pool
   import sched_pkg::*;
(
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   // take the currently offered id
   input  wire logic                   alloc_i,
   // ids released this cycle
   input  wire logic [NUM_ENTRIES-1:0] dealloc_oh_i,
   output logic      [NUM_ENTRIES-1:0] active_o,
   output logic      [NUM_ENTRIES-1:0] free_oh_o,
   output logic                        free_v_o
);

   // one bit per entry, set while the id is in flight
   logic [NUM_ENTRIES-1:0] active_r;
   logic [NUM_ENTRIES-1:0] free_vec;
   logic [NUM_ENTRIES-1:0] set_vec;
   logic [NUM_ENTRIES-1:0] active_nxt;

   // ------------------------------------------------
   // free id selection
   // ------------------------------------------------

   assign free_vec = ~active_r;

   // isolate the lowest set bit of the free vector
   // zero when the pool is full
   assign free_oh_o = free_vec & (~free_vec + NUM_ENTRIES'(1));

   assign free_v_o = |free_vec;

   assign active_o = active_r;

   // ------------------------------------------------
   // active bitmap update
   // ------------------------------------------------

   // set the offered id only when the caller takes it
   assign set_vec = {NUM_ENTRIES{alloc_i}} & free_oh_o;

   // released ids drop out here and can be offered again next cycle
   // alloc and dealloc never overlap on the same id since the offered id is free
   assign active_nxt = (active_r & ~dealloc_oh_i) | set_vec;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         // all ids free after reset
         active_r <= '0;
      end
      else
      begin
         active_r <= active_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/payload_store.sv ====
// ------------------------------------------------
// payload store
// single-port memory shared by enqueue writes and
// issue reads, the write always wins the port
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module payload_store
   import sched_pkg::*;
(
   input  wire logic            clk_i,
   input  wire logic            rst_i,

   // write peer, enqueue side
   input  wire logic            wr_req_i,
   input  wire logic [ID_W-1:0] wr_id_i,
   input  wire payload_t        wr_data_i,

   // read peer, issue side
   input  wire logic            rd_req_i,
   input  wire logic [ID_W-1:0] rd_id_i,
   output logic                 rd_grant_o,

   // registered read result
   output logic                 rd_v_o,
   output logic      [ID_W-1:0] rd_id_o,
   output payload_t             rd_data_o
);

   payload_t        mem [NUM_ENTRIES];
   logic [ID_W-1:0] port_addr;

   // ------------------------------------------------
   // port arbitration
   // ------------------------------------------------

   // read gets the port only in a cycle without a write
   assign rd_grant_o = rd_req_i & ~wr_req_i;

   // one address for the single port
   assign port_addr = wr_req_i ? wr_id_i : rd_id_i;

   // ------------------------------------------------
   // memory port
   // ------------------------------------------------

   always_ff @(posedge clk_i)
   begin
      if (wr_req_i)
      begin
         mem[port_addr] <= wr_data_i;
      end
      else if (rd_grant_o)
      begin
         // data and id held until the next granted read
         rd_data_o <= mem[port_addr];
         rd_id_o   <= port_addr;
      end
   end

   // valid strobe for exactly one cycle after a grant
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rd_v_o <= 1'b0;
      end
      else
      begin
         rd_v_o <= rd_grant_o;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/resource_scheduler.sv ====
// ------------------------------------------------
// level-sensitive resource scheduler
// hands out entry ids, holds dependency indices and
// picks ready entries round-robin, no payload kept
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module resource_scheduler
   import sched_pkg::*;
(
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,

   // availability bitmaps, sampled every cycle
   input  wire logic [NUM_RES-1:0][DEP_BITS-1:0] res_avail_i,

   // allocate side
   input  wire logic                             alloc_v_i,
   input  wire logic [NUM_RES-1:0][DEP_W-1:0]    alloc_sel_i,
   output logic                                  alloc_fire_o,
   output logic      [ID_W-1:0]                  alloc_id_o,

   // dequeue side
   output logic                                  deq_v_o,
   output logic      [ID_W-1:0]                  deq_id_o,
   input  wire logic                             deq_yumi_i
);

   logic [NUM_ENTRIES-1:0] active;
   logic [NUM_ENTRIES-1:0] free_oh;
   logic                   free_v;
   logic [NUM_ENTRIES-1:0] entry_ready;
   logic [NUM_ENTRIES-1:0] grant_oh;
   logic [NUM_ENTRIES-1:0] dealloc_oh;

   // dependency indices per entry, one per resource
   logic [NUM_ENTRIES-1:0][NUM_RES-1:0][DEP_W-1:0] sel_idx_r;

   // or-reduction encoder, input is one-hot or zero
   function automatic logic [ID_W-1:0] oh_to_id(input logic [NUM_ENTRIES-1:0] oh);
      logic [ID_W-1:0] id;
      id = '0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (oh[i])
         begin
            id = id | ID_W'(i);
         end
      end
      return id;
   endfunction

   // ------------------------------------------------
   // allocation
   // ------------------------------------------------

   id_pool u_id_pool (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .alloc_i      (alloc_fire_o),
      .dealloc_oh_i (dealloc_oh),
      .active_o     (active),
      .free_oh_o    (free_oh),
      .free_v_o     (free_v)
   );

   // request without a free id is dropped
   assign alloc_fire_o = alloc_v_i & free_v;
   assign alloc_id_o   = oh_to_id(free_oh);

   // capture the indices of the new entry
   always_ff @(posedge clk_i)
   begin
      if (alloc_fire_o)
      begin
         sel_idx_r[alloc_id_o] <= alloc_sel_i;
      end
   end

   // ------------------------------------------------
   // readiness
   // ------------------------------------------------

   // AND of the selected bit of every resource
   for (genvar e = 0; e < NUM_ENTRIES; e++)
   begin : g_ready
      logic [NUM_RES-1:0] res_ok;
      for (genvar r = 0; r < NUM_RES; r++)
      begin : g_res
         // inactive rows never look at their stale indices
         assign res_ok[r] = active[e] ? res_avail_i[r][sel_idx_r[e][r]] : 1'b0;
      end
      assign entry_ready[e] = active[e] & (&res_ok);
   end

   // ------------------------------------------------
   // selection and dequeue
   // ------------------------------------------------

   rr_arbiter u_rr_arbiter (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (entry_ready),
      .accept_i   (deq_yumi_i),
      .grant_oh_o (grant_oh)
   );

   assign deq_v_o  = |entry_ready;
   assign deq_id_o = oh_to_id(grant_oh);

   // accepted entry goes back to the pool
   assign dealloc_oh = grant_oh & {NUM_ENTRIES{deq_yumi_i}};

endmodule

`default_nettype wire

// ==== rtl/rr_arbiter.sv ====
// ------------------------------------------------
// round-robin arbiter
// one-hot grant to the first requester at or after
// the pointer, pointer moves past an accepted grant
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
   import sched_pkg::*;
(
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire logic [NUM_ENTRIES-1:0] req_i,
   // the granted requester was taken this cycle
   input  wire logic                   accept_i,
   output logic      [NUM_ENTRIES-1:0] grant_oh_o
);

   // index with the highest priority this cycle
   logic [ID_W-1:0] ptr_r;
   logic [ID_W-1:0] ptr_nxt;
   logic [ID_W-1:0] grant_idx;
   logic            grant_found;

   // ------------------------------------------------
   // grant selection
   // ------------------------------------------------

   // walk the offsets from far to near so the nearest requester is written last
   always_comb
   begin
      grant_idx = ptr_r;
      for (int k = NUM_ENTRIES - 1; k >= 0; k--)
      begin
         if (req_i[(int'(ptr_r) + k) % NUM_ENTRIES])
         begin
            grant_idx = ID_W'((int'(ptr_r) + k) % NUM_ENTRIES);
         end
      end
   end

   assign grant_found = |req_i;

   assign grant_oh_o = grant_found ? (NUM_ENTRIES'(1) << grant_idx) : '0;

   // ------------------------------------------------
   // pointer
   // ------------------------------------------------

   // one past the granted index, wrapping at the last entry
   assign ptr_nxt = (grant_idx == ID_W'(NUM_ENTRIES - 1)) ? '0 : grant_idx + ID_W'(1);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         ptr_r <= '0;
      end
      else if (accept_i && grant_found)
      begin
         ptr_r <= ptr_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/sched_pkg.sv ====
// ------------------------------------------------
// issue scheduler shared definitions
// sizes, derived widths and the payload word type
// ------------------------------------------------

`default_nettype none

package sched_pkg;

   // ------------------------------------------------
   // sizes
   // ------------------------------------------------

   // number of level-sensitive resources an entry depends on
   localparam int NUM_RES     = 2;
   // width of each resource availability bitmap
   localparam int DEP_BITS    = 8;
   // entries in flight at most
   localparam int NUM_ENTRIES = 8;

   // ------------------------------------------------
   // derived widths
   // ------------------------------------------------

   // index into one availability bitmap
   localparam int DEP_W  = $clog2(DEP_BITS);
   // binary entry id
   localparam int ID_W   = $clog2(NUM_ENTRIES);
   // payload word width
   localparam int DATA_W = 16;

   // payload carried from enqueue to issue
   typedef logic [DATA_W-1:0] payload_t;

endpackage

`default_nettype wire

// ==== rtl/sched_top.sv ====
// ------------------------------------------------
// issue scheduler top level
// ties the scheduler and the payload store to the
// enqueue, resource and issue ports
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sched_top
   import sched_pkg::*;
(
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,

   // ------------------------------------------------
   // enqueue, answered in the same cycle
   // ------------------------------------------------
   input  wire logic                             enq_v_i,
   input  wire logic [NUM_RES-1:0][DEP_W-1:0]    enq_sel_i,
   input  wire payload_t                         enq_data_i,
   output logic                                  enq_ok_o,
   output logic      [ID_W-1:0]                  enq_id_o,

   // ------------------------------------------------
   // resource availability
   // ------------------------------------------------
   input  wire logic [NUM_RES-1:0][DEP_BITS-1:0] res_avail_i,

   // ------------------------------------------------
   // issue strobe, no back-pressure
   // ------------------------------------------------
   output logic                                  iss_v_o,
   output logic      [ID_W-1:0]                  iss_id_o,
   output payload_t                              iss_data_o
);

   // read request from the scheduler
   logic            deq_v;
   logic [ID_W-1:0] deq_id;
   // read won the store port, entry leaves the scheduler
   logic            rd_grant;

   // accepted enqueue doubles as the store write request
   resource_scheduler u_scheduler (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .res_avail_i  (res_avail_i),
      .alloc_v_i    (enq_v_i),
      .alloc_sel_i  (enq_sel_i),
      .alloc_fire_o (enq_ok_o),
      .alloc_id_o   (enq_id_o),
      .deq_v_o      (deq_v),
      .deq_id_o     (deq_id),
      .deq_yumi_i   (rd_grant)
   );

   // registered read result is the issue output
   payload_store u_store (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_req_i   (enq_ok_o),
      .wr_id_i    (enq_id_o),
      .wr_data_i  (enq_data_i),
      .rd_req_i   (deq_v),
      .rd_id_i    (deq_id),
      .rd_grant_o (rd_grant),
      .rd_v_o     (iss_v_o),
      .rd_id_o    (iss_id_o),
      .rd_data_o  (iss_data_o)
   );

endmodule

`default_nettype wire

// ==== tb/sched_asserts.sv ====
// ------------------------------------------------
// payload store port checks
// one port owner per cycle, read valid one cycle
// after every read grant and never otherwise
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sched_asserts
(
   input  wire logic clk_i,
   input  wire logic rst_i,
   input  wire logic wr_req_i,
   input  wire logic rd_grant_i,
   input  wire logic rd_v_i
);

   // count of failed assertions that the testbench top reads
   int fail_cnt = 0;

   // never a read and a write on the single port in one cycle
   a_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
      !(rd_grant_i && wr_req_i))
   else
   begin
      fail_cnt++;
      $error("read granted in a cycle with a write");
   end

   // read data valid exactly one cycle after the grant
   a_valid_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_grant_i |=> rd_v_i)
   else
   begin
      fail_cnt++;
      $error("no read valid after a read grant");
   end

   a_valid_only_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
      !rd_grant_i |=> !rd_v_i)
   else
   begin
      fail_cnt++;
      $error("read valid without a read grant");
   end

endmodule

`default_nettype wire

// ==== tb/sched_checker.sv ====
// ------------------------------------------------
// issue scheduler reference model
// watches the DUT ports each clock, predicts ids,
// grants and payloads, counts mismatches
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sched_checker
   import sched_pkg::*;
(
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,
   input  wire logic                             enq_v_i,
   input  wire logic [NUM_RES-1:0][DEP_W-1:0]    enq_sel_i,
   input  wire payload_t                         enq_data_i,
   input  wire logic                             enq_ok_i,
   input  wire logic [ID_W-1:0]                  enq_id_i,
   input  wire logic [NUM_RES-1:0][DEP_BITS-1:0] res_avail_i,
   input  wire logic                             iss_v_i,
   input  wire logic [ID_W-1:0]                  iss_id_i,
   input  wire payload_t                         iss_data_i,
   output int                                    alloc_errs_o,
   output int                                    issue_errs_o
);

   // model state
   logic [NUM_ENTRIES-1:0]        active_m;
   logic [NUM_RES-1:0][DEP_W-1:0] sel_m [NUM_ENTRIES];
   payload_t                      data_m [NUM_ENTRIES];
   int                            ptr_m;
   // issue predicted for the coming cycle
   logic                          exp_v;
   int                            exp_id;
   payload_t                      exp_data;

   initial
   begin
      alloc_errs_o = 0;
      issue_errs_o = 0;
   end

   // all port values sampled here belong to the cycle ending at this edge
   always @(posedge clk_i)
   begin
      int                     free_id;
      int                     grant_id;
      int                     idx;
      logic                   ok_m;
      logic [NUM_ENTRIES-1:0] ready;
      if (rst_i)
      begin
         active_m = '0;
         ptr_m    = 0;
         exp_v    = 1'b0;
      end
      else
      begin
         // ------------------------------------------------
         // issue seen now was granted last cycle
         // ------------------------------------------------
         if (iss_v_i !== exp_v)
         begin
            issue_errs_o++;
            $display("CHECK FAILED t=%0t iss_v_o exp %0b got %0b", $time, exp_v, iss_v_i);
         end
         else if (exp_v)
         begin
            if (iss_id_i !== ID_W'(exp_id))
            begin
               issue_errs_o++;
               $display("CHECK FAILED t=%0t iss_id_o exp %0d got %0d", $time, exp_id, iss_id_i);
            end
            if (iss_data_i !== exp_data)
            begin
               issue_errs_o++;
               $display("CHECK FAILED t=%0t iss_data_o exp %h got %h",
                        $time, exp_data, iss_data_i);
            end
         end

         // ------------------------------------------------
         // allocation, lowest free id
         // ------------------------------------------------
         free_id = -1;
         for (int i = NUM_ENTRIES - 1; i >= 0; i--)
         begin
            if (!active_m[i])
            begin
               free_id = i;
            end
         end
         ok_m = enq_v_i && (free_id >= 0);
         if (enq_ok_i !== ok_m)
         begin
            alloc_errs_o++;
            $display("CHECK FAILED t=%0t enq_ok_o exp %0b got %0b", $time, ok_m, enq_ok_i);
         end
         else if (ok_m && (enq_id_i !== ID_W'(free_id)))
         begin
            alloc_errs_o++;
            $display("CHECK FAILED t=%0t enq_id_o exp %0d got %0d", $time, free_id, enq_id_i);
         end

         // ------------------------------------------------
         // readiness and round-robin pick
         // ------------------------------------------------
         for (int e = 0; e < NUM_ENTRIES; e++)
         begin
            ready[e] = active_m[e];
            if (active_m[e])
            begin
               for (int r = 0; r < NUM_RES; r++)
               begin
                  if (res_avail_i[r][sel_m[e][r]] !== 1'b1)
                  begin
                     ready[e] = 1'b0;
                  end
               end
            end
         end
         // far offsets first, so the nearest ready entry wins
         grant_id = -1;
         for (int k = NUM_ENTRIES - 1; k >= 0; k--)
         begin
            idx = (ptr_m + k) % NUM_ENTRIES;
            if (ready[idx])
            begin
               grant_id = idx;
            end
         end
         // an accepted enqueue takes the store port
         exp_v = 1'b0;
         if (!ok_m && (grant_id >= 0))
         begin
            exp_v              = 1'b1;
            exp_id             = grant_id;
            exp_data           = data_m[grant_id];
            active_m[grant_id] = 1'b0;
            ptr_m              = (grant_id + 1) % NUM_ENTRIES;
         end
         // new entry is eligible from the next cycle
         if (ok_m)
         begin
            active_m[free_id] = 1'b1;
            sel_m[free_id]    = enq_sel_i;
            data_m[free_id]   = enq_data_i;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_sched.sv ====
// ------------------------------------------------
// issue scheduler testbench
// applies a stimulus table to the DUT, the checker
// compares, a watchdog bounds the run
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_sched
   import sched_pkg::*;
();

   localparam int MAX_ROWS = 64;

   logic                             clk;
   logic                             rst;
   logic                             enq_v;
   logic [NUM_RES-1:0][DEP_W-1:0]    enq_sel;
   payload_t                         enq_data;
   logic                             enq_ok;
   logic [ID_W-1:0]                  enq_id;
   logic [NUM_RES-1:0][DEP_BITS-1:0] res_avail;
   logic                             iss_v;
   logic [ID_W-1:0]                  iss_id;
   payload_t                         iss_data;
   int                               alloc_errs;
   int                               issue_errs;
   int                               assert_errs;

   // ------------------------------------------------
   // stimulus table with one row per held input set
   // ------------------------------------------------
   logic                             row_v     [MAX_ROWS];
   logic [NUM_RES-1:0][DEP_W-1:0]    row_sel   [MAX_ROWS];
   payload_t                         row_data  [MAX_ROWS];
   logic [NUM_RES-1:0][DEP_BITS-1:0] row_avail [MAX_ROWS];
   int                               row_hold  [MAX_ROWS];
   int                               num_rows;
   int                               total_cycles;
   int                               seed;
   logic                             table_ready;

   sched_top u_sched_top (
      .clk_i       (clk),
      .rst_i       (rst),
      .enq_v_i     (enq_v),
      .enq_sel_i   (enq_sel),
      .enq_data_i  (enq_data),
      .enq_ok_o    (enq_ok),
      .enq_id_o    (enq_id),
      .res_avail_i (res_avail),
      .iss_v_o     (iss_v),
      .iss_id_o    (iss_id),
      .iss_data_o  (iss_data)
   );

   sched_checker u_checker (
      .clk_i        (clk),
      .rst_i        (rst),
      .enq_v_i      (enq_v),
      .enq_sel_i    (enq_sel),
      .enq_data_i   (enq_data),
      .enq_ok_i     (enq_ok),
      .enq_id_i     (enq_id),
      .res_avail_i  (res_avail),
      .iss_v_i      (iss_v),
      .iss_id_i     (iss_id),
      .iss_data_i   (iss_data),
      .alloc_errs_o (alloc_errs),
      .issue_errs_o (issue_errs)
   );

   // port checks live inside the store
   bind payload_store sched_asserts u_store_asserts (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_req_i   (wr_req_i),
      .rd_grant_i (rd_grant_o),
      .rd_v_i     (rd_v_o)
   );

   assign assert_errs = u_sched_top.u_store.u_store_asserts.fail_cnt;

   // 10 ns clock
   always #5 clk = ~clk;

   // payload of every row comes from the seeded generator
   task automatic add_row(input logic v, input logic [NUM_RES-1:0][DEP_W-1:0] sel,
                          input logic [NUM_RES-1:0][DEP_BITS-1:0] avail, input int hold);
      row_v[num_rows]     = v;
      row_sel[num_rows]   = sel;
      row_data[num_rows]  = payload_t'($random(seed));
      row_avail[num_rows] = avail;
      row_hold[num_rows]  = hold;
      total_cycles        = total_cycles + hold;
      num_rows            = num_rows + 1;
   endtask

   task automatic build_table();
      logic                             rnd_v;
      logic [NUM_RES-1:0][DEP_W-1:0]    rnd_sel;
      logic [NUM_RES-1:0][DEP_BITS-1:0] rnd_avail;
      int                               rnd_hold;
      add_row(1'b0, '0, '0, 3);
      // fill the pool while nothing is ready
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         add_row(1'b1, {DEP_W'(i), DEP_W'(7 - i)}, '0, 1);
      end
      // pool is full so these two are dropped
      add_row(1'b1, '0, '0, 2);
      // everything ready so the pool drains in round-robin order
      add_row(1'b0, '0, 16'hffff, 12);
      // one entry ready and one waiting on resource 1 bit 4
      add_row(1'b1, {3'd5, 3'd3}, 16'h2008, 1);
      add_row(1'b1, {3'd4, 3'd3}, 16'h2008, 1);
      add_row(1'b0, '0, 16'h2008, 3);
      add_row(1'b0, '0, 16'h3008, 2);
      // back-to-back enqueues stall ready entries
      add_row(1'b1, {3'd0, 3'd0}, 16'h0101, 3);
      add_row(1'b0, '0, 16'h0101, 4);
      // random mix
      for (int i = 0; i < 24; i++)
      begin
         rnd_v     = 1'(($random(seed)) & 1);
         rnd_sel   = (NUM_RES * DEP_W)'($random(seed));
         rnd_avail = (NUM_RES * DEP_BITS)'(($random(seed)) | ($random(seed)));
         rnd_hold  = 1 + ($unsigned($random(seed)) % 3);
         add_row(rnd_v, rnd_sel, rnd_avail, rnd_hold);
      end
      add_row(1'b0, '0, 16'hffff, 16);
   endtask

   // ------------------------------------------------
   // main sequence
   // ------------------------------------------------
   initial
   begin
      clk          = 1'b0;
      rst          = 1'b1;
      enq_v        = 1'b0;
      enq_sel      = '0;
      enq_data     = '0;
      res_avail    = '0;
      seed         = 57431;
      num_rows     = 0;
      total_cycles = 0;
      table_ready  = 1'b0;
      build_table();
      table_ready  = 1'b1;

      repeat (10) @(posedge clk);
      rst <= 1'b0;

      for (int i = 0; i < num_rows; i++)
      begin
         for (int h = 0; h < row_hold[i]; h++)
         begin
            @(posedge clk);
            enq_v     <= row_v[i];
            enq_sel   <= row_sel[i];
            enq_data  <= row_data[i];
            res_avail <= row_avail[i];
         end
      end
      // let the last issue reach the checker
      @(posedge clk);
      enq_v <= 1'b0;
      repeat (3) @(posedge clk);

      $display("errors: alloc %0d, issue %0d, assertion %0d",
               alloc_errs, issue_errs, assert_errs);
      if ((alloc_errs + issue_errs + assert_errs) == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog bounds the run to the table length plus margin
   initial
   begin
      wait (table_ready === 1'b1);
      #((total_cycles + 50) * 10);
      $display("watchdog: run did not finish within %0d cycles", total_cycles + 50);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire
